//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and storage sizes
`define CORE_XLEN       32
`define CORE_NREG       32
`define CORE_IMM_W      16
`define CORE_IADDR_W    13
`define CORE_DADDR_W    17
`define CORE_WIN_DEPTH  3

// cycles from a read strobe to valid read data
`define CORE_DMEM_LAT   1

// instruction fields: op[31:29] rs[25:21] rt[20:16] rd[15:11] imm[15:0]
`define CORE_OP_LSB     29
`define CORE_RS_LSB     21
`define CORE_RT_LSB     16
`define CORE_RD_LSB     11

`define CORE_OP_NOP     3'd0
`define CORE_OP_ADD     3'd1
`define CORE_OP_SUB     3'd2
`define CORE_OP_AND     3'd3
`define CORE_OP_OR      3'd4
`define CORE_OP_ADDI    3'd5
`define CORE_OP_LW      3'd6
`define CORE_OP_SW      3'd7

`endif

//--- core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0]          xword_t;
	typedef logic [$clog2(`CORE_NREG)-1:0]  reg_idx_t;
	typedef logic [`CORE_IMM_W-1:0]         imm_t;
	typedef logic [`CORE_IADDR_W-1:0]       iaddr_t;
	typedef logic [`CORE_DADDR_W-1:0]       daddr_t;
	typedef logic [`CORE_NREG-1:0]          sb_mask_t;

	typedef enum logic [2:0] {
		OP_NOP  = `CORE_OP_NOP,
		OP_ADD  = `CORE_OP_ADD,
		OP_SUB  = `CORE_OP_SUB,
		OP_AND  = `CORE_OP_AND,
		OP_OR   = `CORE_OP_OR,
		OP_ADDI = `CORE_OP_ADDI,
		OP_LW   = `CORE_OP_LW,
		OP_SW   = `CORE_OP_SW
	} op_e;

	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_LSU = 1'b1
	} unit_e;

	// rd/rs/rt of zero mean no register
	typedef struct packed {
		op_e      op;
		unit_e    unit;
		reg_idx_t rd;
		reg_idx_t rs;
		reg_idx_t rt;
		imm_t     imm;
		logic     valid;
	} uop_t;

	typedef struct packed {
		uop_t   uop;
		xword_t rs_val;
		xword_t rt_val;
	} issue_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		xword_t   val;
	} wb_req_t;

endpackage

//--- fetch_decode.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module fetch_decode import core_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  logic [63:0] i_rdata,
	input  logic        i_window_busy,
	output iaddr_t      o_i_addr,
	output uop_t        o_uop0,
	output uop_t        o_uop1
);

	iaddr_t      pc;
	logic        rdata_vld;
	logic        was_busy;
	logic        hold_load;
	logic [63:0] hold_word;
	logic        hold_vld;
	logic [63:0] cur_word;
	logic        cur_vld;

	function automatic uop_t decode(input logic [31:0] ins, input logic vld);
		uop_t u;
		u = '0;
		u.op = op_e'(ins[`CORE_OP_LSB +: 3]);
		u.rs = ins[`CORE_RS_LSB +: $bits(reg_idx_t)];
		u.imm = ins[`CORE_IMM_W-1:0];
		u.unit = (u.op == OP_LW || u.op == OP_SW) ? UNIT_LSU : UNIT_ALU;
		case (u.op)
			OP_ADD, OP_SUB, OP_AND, OP_OR: begin
				u.rd = ins[`CORE_RD_LSB +: $bits(reg_idx_t)];
				u.rt = ins[`CORE_RT_LSB +: $bits(reg_idx_t)];
			end
			// rt field is the destination here
			OP_ADDI, OP_LW: u.rd = ins[`CORE_RT_LSB +: $bits(reg_idx_t)];
			OP_SW: u.rt = ins[`CORE_RT_LSB +: $bits(reg_idx_t)];
			default: u.rs = '0;
		endcase
		u.valid = vld && (u.op != OP_NOP);
		return u;
	endfunction

	assign o_i_addr = pc;

	// first stall cycle captures the pair that missed the window
	assign hold_load = i_window_busy && !was_busy;
	assign cur_word = was_busy ? hold_word : i_rdata;
	assign cur_vld = was_busy ? hold_vld : rdata_vld;

	// bits 63:32 are the older slot
	assign o_uop0 = decode(cur_word[63:32], cur_vld);
	assign o_uop1 = decode(cur_word[31:0], cur_vld);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= '0;
			rdata_vld <= 1'b0;
			was_busy <= 1'b0;
		end else begin
			rdata_vld <= 1'b1;
			was_busy <= i_window_busy;
			if (!i_window_busy)
				pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_load) begin
			hold_word <= i_rdata;
			hold_vld <= rdata_vld;
		end
	end

	assert property (@(posedge clk) disable iff (!rstn)
		was_busy && i_window_busy |=> $stable(hold_word) && $stable(hold_vld));

endmodule

//--- issue_window.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module issue_window import core_pkg::*; (
	input  logic     clk,
	input  logic     rstn,
	input  uop_t     i_uop0,
	input  uop_t     i_uop1,
	input  xword_t   i_rs_val [`CORE_WIN_DEPTH],
	input  xword_t   i_rt_val [`CORE_WIN_DEPTH],
	input  sb_mask_t i_sb_clear,
	input  logic     i_alu_busy,
	input  logic     i_lsu_busy,
	output logic     o_window_busy,
	output reg_idx_t o_rs_idx [`CORE_WIN_DEPTH],
	output reg_idx_t o_rt_idx [`CORE_WIN_DEPTH],
	output issue_t   o_alu_issue,
	output issue_t   o_lsu_issue,
	output logic     o_alu_go,
	output logic     o_lsu_go
);

	localparam int DEPTH = `CORE_WIN_DEPTH;
	localparam int SEL_W = $clog2(DEPTH);

	uop_t             win [DEPTH];
	uop_t             win_nxt [DEPTH];
	sb_mask_t         board;
	sb_mask_t         src_m [DEPTH];
	sb_mask_t         dst_m [DEPTH];
	sb_mask_t         older_wr;
	sb_mask_t         older_rw;
	sb_mask_t         sb_set;
	logic [DEPTH-1:0] ready;
	logic [DEPTH-1:0] issued;
	logic [SEL_W-1:0] alu_sel;
	logic [SEL_W-1:0] lsu_sel;
	logic             lsu_found;
	logic [2:0]       fill_cnt;

	function automatic sb_mask_t reg_bit(input reg_idx_t idx);
		sb_mask_t m;
		m = '0;
		if (idx != '0)
			m[idx] = 1'b1;
		return m;
	endfunction

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			src_m[i] = win[i].valid ? (reg_bit(win[i].rs) | reg_bit(win[i].rt)) : '0;
			dst_m[i] = win[i].valid ? reg_bit(win[i].rd) : '0;
			o_rs_idx[i] = win[i].rs;
			o_rt_idx[i] = win[i].rt;
		end
	end

	// entry 0 is the oldest
	always_comb begin
		older_wr = '0;
		older_rw = '0;
		for (int i = 0; i < DEPTH; i++) begin
			ready[i] = win[i].valid && ((board & (src_m[i] | dst_m[i])) == '0)
				&& ((older_wr & src_m[i]) == '0) && ((older_rw & dst_m[i]) == '0);
			older_wr = older_wr | dst_m[i];
			older_rw = older_rw | src_m[i] | dst_m[i];
		end
	end

	// walk young to old so the oldest match wins
	always_comb begin
		alu_sel = '0;
		lsu_sel = '0;
		lsu_found = 1'b0;
		o_alu_go = 1'b0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ready[i] && win[i].unit == UNIT_ALU) begin
				alu_sel = SEL_W'(i);
				o_alu_go = !i_alu_busy;
			end
			if (win[i].valid && win[i].unit == UNIT_LSU) begin
				lsu_sel = SEL_W'(i);
				lsu_found = 1'b1;
			end
		end
		// memory ops stay in program order
		o_lsu_go = lsu_found && ready[lsu_sel] && !i_lsu_busy;
	end

	always_comb begin
		issued = '0;
		sb_set = '0;
		if (o_alu_go) begin
			issued[alu_sel] = 1'b1;
			sb_set = sb_set | dst_m[alu_sel];
		end
		if (o_lsu_go) begin
			issued[lsu_sel] = 1'b1;
			sb_set = sb_set | dst_m[lsu_sel];
		end
	end

	// compact survivors, then append the decoded pair
	always_comb begin
		for (int i = 0; i < DEPTH; i++)
			win_nxt[i] = '0;
		fill_cnt = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (win[i].valid && !issued[i]) begin
				win_nxt[fill_cnt[SEL_W-1:0]] = win[i];
				fill_cnt = fill_cnt + 1'b1;
			end
		end
		o_window_busy = (fill_cnt >= 3'd2);
		if (!o_window_busy) begin
			if (i_uop0.valid) begin
				if (fill_cnt < 3'(DEPTH))
					win_nxt[fill_cnt[SEL_W-1:0]] = i_uop0;
				fill_cnt = fill_cnt + 1'b1;
			end
			if (i_uop1.valid) begin
				if (fill_cnt < 3'(DEPTH))
					win_nxt[fill_cnt[SEL_W-1:0]] = i_uop1;
				fill_cnt = fill_cnt + 1'b1;
			end
		end
	end

	assign o_alu_issue = '{uop: win[alu_sel], rs_val: i_rs_val[alu_sel],
		rt_val: i_rt_val[alu_sel]};
	assign o_lsu_issue = '{uop: win[lsu_sel], rs_val: i_rs_val[lsu_sel],
		rt_val: i_rt_val[lsu_sel]};

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < DEPTH; i++)
				win[i] <= '0;
			board <= '0;
		end else begin
			for (int i = 0; i < DEPTH; i++)
				win[i] <= win_nxt[i];
			board <= (board & ~i_sb_clear) | sb_set;
		end
	end

	assert property (@(posedge clk) disable iff (!rstn) fill_cnt <= 3'(DEPTH));

	assert property (@(posedge clk) disable iff (!rstn)
		!(o_alu_go && i_alu_busy) && !(o_lsu_go && i_lsu_busy));

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module reg_file import core_pkg::*; (
	input  logic     clk,
	input  reg_idx_t i_rs_idx [`CORE_WIN_DEPTH],
	input  reg_idx_t i_rt_idx [`CORE_WIN_DEPTH],
	output xword_t   o_rs_val [`CORE_WIN_DEPTH],
	output xword_t   o_rt_val [`CORE_WIN_DEPTH],
	input  logic     i_we,
	input  reg_idx_t i_wr_idx,
	input  xword_t   i_wr_val
);

	xword_t regs [`CORE_NREG];

	always_ff @(posedge clk) begin
		if (i_we)
			regs[i_wr_idx] <= i_wr_val;
	end

	// one read pair per window slot, r0 hardwired
	always_comb begin
		for (int i = 0; i < `CORE_WIN_DEPTH; i++) begin
			o_rs_val[i] = (i_rs_idx[i] == '0) ? '0 : regs[i_rs_idx[i]];
			o_rt_val[i] = (i_rt_idx[i] == '0) ? '0 : regs[i_rt_idx[i]];
		end
	end

endmodule

//--- alu_unit.sv
`timescale 1ns/10ps

module alu_unit import core_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  logic    i_go,
	input  issue_t  i_issue,
	input  logic    i_grant,
	output logic    o_busy,
	output wb_req_t o_wb
);

	xword_t  imm_ext;
	xword_t  result;
	wb_req_t res_q;

	assign imm_ext = xword_t'($signed(i_issue.uop.imm));

	always_comb begin
		case (i_issue.uop.op)
			OP_ADD:  result = i_issue.rs_val + i_issue.rt_val;
			OP_SUB:  result = i_issue.rs_val - i_issue.rt_val;
			OP_AND:  result = i_issue.rs_val & i_issue.rt_val;
			OP_OR:   result = i_issue.rs_val | i_issue.rt_val;
			OP_ADDI: result = i_issue.rs_val + imm_ext;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			res_q.valid <= 1'b0;
		end else if (i_go) begin
			res_q.valid <= 1'b1;
			res_q.rd <= i_issue.uop.rd;
			res_q.val <= result;
		end else if (i_grant) begin
			res_q.valid <= 1'b0;
		end
	end

	// a granted result frees the unit in the same cycle
	assign o_busy = res_q.valid && !i_grant;
	assign o_wb = res_q;

	assert property (@(posedge clk) disable iff (!rstn)
		res_q.valid && !i_grant |=> $stable(res_q));

endmodule

//--- lsu_unit.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module lsu_unit import core_pkg::*; (
	input  logic    clk,
	input  logic    rstn,
	input  logic    i_go,
	input  issue_t  i_issue,
	input  logic    i_grant,
	input  xword_t  i_d_rdata,
	output daddr_t  o_d_addr,
	output xword_t  o_d_wdata,
	output logic    o_d_en,
	output logic    o_d_we,
	output logic    o_busy,
	output wb_req_t o_wb
);

	typedef enum logic [1:0] {S_IDLE, S_MEM, S_WB} lsu_state_e;

	lsu_state_e state;
	xword_t     eff_addr;
	reg_idx_t   ld_rd;
	logic       is_load;
	logic [2:0] lat_cnt;
	logic       wb_first;
	xword_t     ld_hold;

	assign eff_addr = i_issue.rs_val + xword_t'($signed(i_issue.uop.imm));

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= S_IDLE;
			o_d_en <= 1'b0;
			o_d_we <= 1'b0;
		end else begin
			o_d_en <= 1'b0;
			o_d_we <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_go) begin
						state <= S_MEM;
						o_d_en <= 1'b1;
						o_d_we <= (i_issue.uop.op == OP_SW);
					end
				end
				// stores finish here, loads wait out the memory latency
				S_MEM: begin
					if (!is_load)
						state <= S_IDLE;
					else if (lat_cnt == 3'd1)
						state <= S_WB;
				end
				S_WB: begin
					if (i_grant)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_go) begin
			o_d_addr <= eff_addr[$bits(daddr_t)-1:0];
			o_d_wdata <= i_issue.rt_val;
			ld_rd <= i_issue.uop.rd;
			is_load <= (i_issue.uop.op == OP_LW);
			lat_cnt <= 3'(`CORE_DMEM_LAT);
		end else if (state == S_MEM) begin
			lat_cnt <= lat_cnt - 1'b1;
		end
		wb_first <= (state == S_MEM);
		if (state == S_WB)
			ld_hold <= o_wb.val;
	end

	// read data is live only in the first writeback cycle
	always_comb begin
		o_wb.valid = (state == S_WB);
		o_wb.rd = ld_rd;
		o_wb.val = wb_first ? i_d_rdata : ld_hold;
	end

	// new ops are accepted only from idle
	assign o_busy = (state != S_IDLE);

	assert property (@(posedge clk) disable iff (!rstn) o_d_we |-> o_d_en);

	assert property (@(posedge clk) disable iff (!rstn)
		o_d_en && !o_d_we |-> ##(`CORE_DMEM_LAT) o_wb.valid);

endmodule

//--- wb_arbiter.sv
`timescale 1ns/10ps

module wb_arbiter import core_pkg::*; (
	input  wb_req_t  i_alu_wb,
	input  wb_req_t  i_lsu_wb,
	output logic     o_alu_grant,
	output logic     o_lsu_grant,
	output logic     o_we,
	output reg_idx_t o_wr_idx,
	output xword_t   o_wr_val,
	output sb_mask_t o_sb_clear
);

	wb_req_t win_req;

	// fixed priority, loads retire first
	assign o_lsu_grant = i_lsu_wb.valid;
	assign o_alu_grant = i_alu_wb.valid && !i_lsu_wb.valid;
	assign win_req = o_lsu_grant ? i_lsu_wb : i_alu_wb;

	// r0 writes still release the unit
	assign o_we = win_req.valid && (win_req.rd != '0);
	assign o_wr_idx = win_req.rd;
	assign o_wr_val = win_req.val;

	always_comb begin
		o_sb_clear = '0;
		if (o_we)
			o_sb_clear[win_req.rd] = 1'b1;
	end

	always_comb begin
		assert (!(o_alu_grant && o_lsu_grant))
			else $error("wb_arbiter: both units granted");
	end

endmodule

//--- core_top.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module core_top import core_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	output iaddr_t      o_i_addr,
	input  logic [63:0] i_i_rdata,
	output daddr_t      o_d_addr,
	output xword_t      o_d_wdata,
	input  xword_t      i_d_rdata,
	output logic        o_d_en,
	output logic        o_d_we
);

	uop_t     uop0;
	uop_t     uop1;
	logic     window_busy;
	reg_idx_t rs_idx [`CORE_WIN_DEPTH];
	reg_idx_t rt_idx [`CORE_WIN_DEPTH];
	xword_t   rs_val [`CORE_WIN_DEPTH];
	xword_t   rt_val [`CORE_WIN_DEPTH];
	issue_t   alu_issue;
	issue_t   lsu_issue;
	logic     alu_go;
	logic     lsu_go;
	logic     alu_busy;
	logic     lsu_busy;
	wb_req_t  alu_wb;
	wb_req_t  lsu_wb;
	logic     alu_grant;
	logic     lsu_grant;
	logic     rf_we;
	reg_idx_t rf_wr_idx;
	xword_t   rf_wr_val;
	sb_mask_t sb_clear;

	fetch_decode u_fd (.clk(clk), .rstn(rstn), .i_rdata(i_i_rdata),
		.i_window_busy(window_busy), .o_i_addr(o_i_addr), .o_uop0(uop0), .o_uop1(uop1));

	issue_window u_iw (.clk(clk), .rstn(rstn), .i_uop0(uop0), .i_uop1(uop1),
		.i_rs_val(rs_val), .i_rt_val(rt_val), .i_sb_clear(sb_clear),
		.i_alu_busy(alu_busy), .i_lsu_busy(lsu_busy), .o_window_busy(window_busy),
		.o_rs_idx(rs_idx), .o_rt_idx(rt_idx), .o_alu_issue(alu_issue),
		.o_lsu_issue(lsu_issue), .o_alu_go(alu_go), .o_lsu_go(lsu_go));

	reg_file u_rf (.clk(clk), .i_rs_idx(rs_idx), .i_rt_idx(rt_idx), .o_rs_val(rs_val),
		.o_rt_val(rt_val), .i_we(rf_we), .i_wr_idx(rf_wr_idx), .i_wr_val(rf_wr_val));

	alu_unit u_alu (.clk(clk), .rstn(rstn), .i_go(alu_go), .i_issue(alu_issue),
		.i_grant(alu_grant), .o_busy(alu_busy), .o_wb(alu_wb));

	lsu_unit u_lsu (.clk(clk), .rstn(rstn), .i_go(lsu_go), .i_issue(lsu_issue),
		.i_grant(lsu_grant), .i_d_rdata(i_d_rdata), .o_d_addr(o_d_addr),
		.o_d_wdata(o_d_wdata), .o_d_en(o_d_en), .o_d_we(o_d_we),
		.o_busy(lsu_busy), .o_wb(lsu_wb));

	wb_arbiter u_wb (.i_alu_wb(alu_wb), .i_lsu_wb(lsu_wb), .o_alu_grant(alu_grant),
		.o_lsu_grant(lsu_grant), .o_we(rf_we), .o_wr_idx(rf_wr_idx),
		.o_wr_val(rf_wr_val), .o_sb_clear(sb_clear));

endmodule

//--- tb_core.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_core import core_pkg::*; ();

	logic        clk = 1'b0;
	logic        rstn;
	iaddr_t      o_i_addr;
	logic [63:0] i_i_rdata;
	daddr_t      o_d_addr;
	xword_t      o_d_wdata;
	xword_t      i_d_rdata;
	logic        o_d_en;
	logic        o_d_we;

	logic [63:0] imem [0:(1 << `CORE_IADDR_W)-1];
	xword_t      dmem [int];
	xword_t      ref_mem [int];
	xword_t      ref_regs [`CORE_NREG];
	logic [31:0] prog [$];
	daddr_t      exp_addr [$];
	xword_t      exp_val [$];
	int          test_end [$];
	int          ref_pc = 0;

	int     seed;
	int     cyc = 0;
	int     cyc_limit = 32'h7fff_ffff;
	int     st_idx = 0;
	daddr_t exp_a;
	xword_t exp_v;
	logic   exp_have;
	int     store_errs = 0;
	int     quiet_errs = 0;
	int     n_pass = 0;
	int     n_fail = 0;
	string  test_name [5] = '{"independent alu ops", "raw and waw chains",
		"store then load", "register 0 writes", "random program"};

	core_top u_dut (.clk(clk), .rstn(rstn), .o_i_addr(o_i_addr), .i_i_rdata(i_i_rdata),
		.o_d_addr(o_d_addr), .o_d_wdata(o_d_wdata), .i_d_rdata(i_d_rdata),
		.o_d_en(o_d_en), .o_d_we(o_d_we));

	always #10 clk = ~clk;

	// untouched data words
	function automatic xword_t fill_word(input daddr_t a);
		return (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic xword_t dmem_read(input daddr_t a);
		return dmem.exists(int'(a)) ? dmem[int'(a)] : fill_word(a);
	endfunction

	function automatic xword_t ref_read(input daddr_t a);
		return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : fill_word(a);
	endfunction

	// two instructions per word, older one in the upper half
	always @(posedge clk)
		i_i_rdata <= imem[o_i_addr];

	always @(posedge clk) begin
		if (rstn && o_d_en && o_d_we)
			dmem[int'(o_d_addr)] = o_d_wdata;
		else if (rstn && o_d_en)
			i_d_rdata <= dmem_read(o_d_addr);
	end

	task automatic emit_rtype(input logic [2:0] op, input int rd, input int rs, input int rt);
		prog.push_back({op, 3'b000, 5'(rs), 5'(rt), 5'(rd), 11'd0});
	endtask

	task automatic emit_itype(input logic [2:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		prog.push_back({op, 3'b000, 5'(rs), 5'(rt), imm});
	endtask

	// in-order model of everything not yet interpreted
	task automatic interpret_rest();
		logic [31:0] ins;
		xword_t      a;
		xword_t      b;
		xword_t      imm_x;
		daddr_t      addr;
		while (ref_pc < prog.size()) begin
			ins = prog[ref_pc];
			a = ref_regs[ins[25:21]];
			b = ref_regs[ins[20:16]];
			imm_x = {{16{ins[15]}}, ins[15:0]};
			addr = daddr_t'(a + imm_x);
			case (ins[31:29])
				`CORE_OP_ADD: ref_regs[ins[15:11]] = a + b;
				`CORE_OP_SUB: ref_regs[ins[15:11]] = a - b;
				`CORE_OP_AND: ref_regs[ins[15:11]] = a & b;
				`CORE_OP_OR: ref_regs[ins[15:11]] = a | b;
				`CORE_OP_ADDI: ref_regs[ins[20:16]] = a + imm_x;
				`CORE_OP_LW: ref_regs[ins[20:16]] = ref_read(addr);
				`CORE_OP_SW: begin
					ref_mem[int'(addr)] = b;
					exp_addr.push_back(addr);
					exp_val.push_back(b);
				end
				default: ;
			endcase
			ref_regs[0] = '0;
			ref_pc++;
		end
		test_end.push_back(exp_addr.size());
	endtask

	function automatic int pick_reg(input int r);
		return ((r & 15) == 15) ? 0 : 20 + (r & 7);
	endfunction

	task automatic build_random(input int n);
		int r1;
		int r2;
		int r3;
		int base;
		for (int k = 20; k < 28; k++)
			emit_itype(`CORE_OP_ADDI, k, 0, 16'($random(seed)));
		for (int k = 0; k < n; k++) begin
			r1 = $random(seed);
			r2 = $random(seed);
			r3 = $random(seed);
			base = ((r2 & 3) == 0) ? pick_reg(r2 >> 2) : 0;
			case ((r1 >>> 8) & 7)
				0: emit_rtype(`CORE_OP_ADD, pick_reg(r1), pick_reg(r2), pick_reg(r3));
				1: emit_rtype(`CORE_OP_SUB, pick_reg(r1), pick_reg(r2), pick_reg(r3));
				2: emit_rtype(`CORE_OP_AND, pick_reg(r1), pick_reg(r2), pick_reg(r3));
				3: emit_rtype(`CORE_OP_OR, pick_reg(r1), pick_reg(r2), pick_reg(r3));
				4: emit_itype(`CORE_OP_ADDI, pick_reg(r1), pick_reg(r2), 16'(r3));
				5: emit_itype(`CORE_OP_LW, pick_reg(r1), base, 16'(r3 & 31));
				default: emit_itype(`CORE_OP_SW, pick_reg(r1), base, 16'(r3 & 31));
			endcase
		end
		emit_itype(`CORE_OP_SW, 20, 0, 16'h0040);
	endtask

	task automatic wait_stores(input int target);
		while (st_idx < target)
			@(posedge clk);
	endtask

	task automatic report_test(input int num, input string name, input logic ok);
		if (ok) begin
			n_pass++;
			$display("test %0d %s: ok", num, name);
		end else begin
			n_fail++;
			$display("test %0d %s: failed", num, name);
		end
	endtask

	// next expected store follows each write strobe
	always @(posedge clk) begin
		if (rstn && o_d_we) begin
			st_idx <= st_idx + 1;
			if (st_idx + 1 < exp_addr.size()) begin
				exp_a <= exp_addr[st_idx + 1];
				exp_v <= exp_val[st_idx + 1];
			end else begin
				exp_have <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= cyc_limit) begin
			$display("timeout after %0d cycles, %0d of %0d stores seen", cyc, st_idx,
				exp_addr.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (!rstn)
		o_d_we |-> exp_have && o_d_addr == exp_a && o_d_wdata == exp_v)
		else begin
			store_errs++;
			$display("mismatch at %0t: store addr %h value %h, expected addr %h value %h",
				$time, $sampled(o_d_addr), $sampled(o_d_wdata), $sampled(exp_a),
				$sampled(exp_v));
		end

	assert property (@(posedge clk) (cyc > 0 && !rstn) |-> !o_d_en && !o_d_we)
		else begin
			quiet_errs++;
			$display("data port strobed during reset at %0t", $time);
		end

	// fetch restarts from word 0 once reset is released
	assert property (@(posedge clk) $rose(rstn) |-> o_i_addr == '0)
		else begin
			quiet_errs++;
			$display("mismatch at %0t: first fetch address %h, expected 0", $time,
				$sampled(o_i_addr));
		end

	// first memory op of the program is a store
	assert property (@(posedge clk) disable iff (!rstn) st_idx == 0 |-> !o_d_en || o_d_we)
		else begin
			quiet_errs++;
			$display("read strobe seen before the first store at %0t", $time);
		end

	initial begin
		int errs0;
		seed = 32'h8e3e;
		rstn = 1'b0;
		i_i_rdata = '0;
		i_d_rdata = '0;
		for (int k = 0; k < `CORE_NREG; k++)
			ref_regs[k] = '0;

		emit_itype(`CORE_OP_ADDI, 1, 0, 16'h0123);
		emit_itype(`CORE_OP_ADDI, 2, 0, 16'hfffb);
		emit_itype(`CORE_OP_ADDI, 3, 0, 16'h7f0f);
		emit_itype(`CORE_OP_ADDI, 4, 0, 16'h00ff);
		emit_itype(`CORE_OP_ADDI, 5, 0, 16'h1000);
		emit_itype(`CORE_OP_ADDI, 7, 0, 16'h0055);
		emit_rtype(`CORE_OP_ADD, 8, 1, 2);
		emit_rtype(`CORE_OP_SUB, 9, 3, 4);
		emit_rtype(`CORE_OP_AND, 10, 3, 4);
		emit_rtype(`CORE_OP_OR, 11, 1, 7);
		emit_itype(`CORE_OP_SW, 8, 5, 16'd0);
		emit_itype(`CORE_OP_SW, 9, 5, 16'd1);
		emit_itype(`CORE_OP_SW, 10, 5, 16'd2);
		emit_itype(`CORE_OP_SW, 11, 5, 16'd3);
		interpret_rest();

		emit_itype(`CORE_OP_ADDI, 12, 1, 16'd1);
		emit_rtype(`CORE_OP_ADD, 12, 12, 12);
		emit_rtype(`CORE_OP_SUB, 13, 12, 1);
		emit_itype(`CORE_OP_ADDI, 13, 13, 16'd7);
		emit_itype(`CORE_OP_ADDI, 14, 0, 16'd9);
		emit_itype(`CORE_OP_ADDI, 14, 0, 16'd11);
		emit_itype(`CORE_OP_SW, 12, 5, 16'd4);
		emit_itype(`CORE_OP_SW, 13, 5, 16'd5);
		emit_itype(`CORE_OP_SW, 14, 5, 16'd6);
		interpret_rest();

		emit_itype(`CORE_OP_ADDI, 15, 0, 16'h02a5);
		emit_itype(`CORE_OP_SW, 15, 5, 16'd8);
		emit_itype(`CORE_OP_LW, 16, 5, 16'd8);
		emit_rtype(`CORE_OP_ADD, 17, 16, 1);
		emit_itype(`CORE_OP_SW, 17, 5, 16'd9);
		emit_itype(`CORE_OP_LW, 18, 0, 16'h0020);
		emit_itype(`CORE_OP_SW, 18, 5, 16'd10);
		interpret_rest();

		emit_itype(`CORE_OP_ADDI, 0, 0, 16'h0077);
		emit_rtype(`CORE_OP_ADD, 0, 1, 7);
		emit_itype(`CORE_OP_LW, 0, 5, 16'd8);
		emit_itype(`CORE_OP_SW, 0, 5, 16'd11);
		emit_rtype(`CORE_OP_ADD, 19, 0, 1);
		emit_itype(`CORE_OP_SW, 19, 5, 16'd12);
		interpret_rest();

		build_random(40);
		interpret_rest();

		for (int k = 0; k < (1 << `CORE_IADDR_W); k++)
			imem[k] = '0;
		for (int k = 0; k < prog.size(); k++) begin
			if (k % 2 == 0)
				imem[k / 2][63:32] = prog[k];
			else
				imem[k / 2][31:0] = prog[k];
		end
		exp_have = 1'b1;
		exp_a = exp_addr[0];
		exp_v = exp_val[0];
		cyc_limit = 20 * prog.size() + 200;

		repeat (10) @(posedge clk);
		rstn <= 1'b1;

		wait_stores(1);
		report_test(1, "reset and idle data port", quiet_errs == 0);
		for (int t = 0; t < 4; t++) begin
			errs0 = store_errs;
			wait_stores(test_end[t]);
			report_test(t + 2, test_name[t], store_errs == errs0);
		end

		errs0 = store_errs;
		wait_stores(test_end[4]);
		// let any stray store show up
		repeat (50) @(posedge clk);
		if (st_idx != exp_addr.size()) begin
			store_errs++;
			$display("mismatch at %0t: %0d stores seen, %0d expected", $time, st_idx,
				exp_addr.size());
		end
		report_test(6, test_name[4], store_errs == errs0);

		$display("tests passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0 && store_errs == 0 && quiet_errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- all.f
+incdir+.
core_pkg.sv
fetch_decode.sv
issue_window.sv
reg_file.sv
alu_unit.sv
lsu_unit.sv
wb_arbiter.sv
core_top.sv
tb_core.sv

//--- Makefile
# Verilator build and run for the scoreboarded core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module tb_core -o tb_core

run: build
	./obj_dir/tb_core | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module core_top

clean:
	rm -rf obj_dir sim.log
